/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module tb_sysarr -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_sysarr)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

/* flist.f */
+incdir+testbench
hdl/sysarr_pkg.sv
hdl/mac_pe.sv
hdl/mac_array.sv
hdl/sysarr_top.sv
testbench/tb_sysarr.sv

/* hdl/mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

// Systolic MAC grid
//   columns (col) run left to right, data flows along them
//   rows (row) run top to bottom, partial sums flow down them
//   batch planes (bat) are stacked, weights pass from one plane to the next
module mac_array #(
  parameter int pe_cols        = 1,
  parameter int pe_rows        = 1,
  parameter int batches        = 1,
  // Let an unaligned-last error reset the core
  parameter int err_self_reset = 0
) (
  input  logic                                              clk,
  input  logic                                              INTERNAL_RESET,

  // Data, indexed batch*pe_rows + row
  input  sysarr_pkg::data_beat_t   [batches*pe_rows-1:0]    data_in,
  input  logic                     [batches*pe_rows-1:0]    data_in_valid,
  output logic                     [batches*pe_rows-1:0]    data_in_ready,

  // Weights into plane 0, indexed row*pe_cols + col
  input  sysarr_pkg::weight_beat_t [pe_rows*pe_cols-1:0]    weight_in,
  input  logic                     [pe_rows*pe_cols-1:0]    weight_in_valid,
  output logic                     [pe_rows*pe_cols-1:0]    weight_in_ready,

  // Results, indexed batch*pe_cols + col
  output sysarr_pkg::rslt_beat_t   [batches*pe_cols-1:0]    rslt_out,
  output logic                     [batches*pe_cols-1:0]    rslt_out_valid,
  input  logic                     [batches*pe_cols-1:0]    rslt_out_ready,

  output logic                                              err_unaligned,
  output logic                                              core_rst
);

  import sysarr_pkg::*;

  localparam int pe_count = pe_cols * pe_rows * batches;
  localparam int lr_nodes = (pe_cols + 1) * pe_rows * batches;
  localparam int tb_nodes = pe_cols * pe_rows * (batches + 1);
  localparam int ud_nodes = pe_cols * (pe_rows + 1) * batches;

  // Left to right data links
  data_beat_t          lr_beat [lr_nodes];
  logic [lr_nodes-1:0] lr_valid;
  logic [lr_nodes-1:0] lr_ready;

  // Plane to plane weight links
  weight_beat_t        tb_beat [tb_nodes];
  logic [tb_nodes-1:0] tb_valid;
  logic [tb_nodes-1:0] tb_ready;

  // Up to down partial-sum links
  psum_beat_t          ud_beat [ud_nodes];
  logic [ud_nodes-1:0] ud_valid;
  logic [ud_nodes-1:0] ud_ready;

  logic [pe_count-1:0] pe_err;
  logic                rst_cause;
  logic [2:0]          rst_pipe;

  assign err_unaligned = |pe_err;

  // Reset cause, optionally including the error flag
  assign rst_cause = INTERNAL_RESET | ((err_self_reset != 0) & err_unaligned);

  // Core reset is stretched for three cycles past its cause
  always_ff @(posedge clk) begin
    rst_pipe <= {rst_pipe[1:0], rst_cause};
    core_rst <= |rst_pipe;
  end

  for (genvar bat = 0; bat < batches; bat++) begin : g_plane
    for (genvar row = 0; row < pe_rows; row++) begin : g_row
      for (genvar col = 0; col < pe_cols; col++) begin : g_col
        localparam int uid    = (bat * pe_rows + row) * pe_cols + col;
        localparam int node_l = (bat * pe_rows + row) * (pe_cols + 1) + col;
        localparam int node_r = (bat * pe_rows + row) * (pe_cols + 1) + col + 1;
        localparam int node_t = (bat * pe_rows + row) * pe_cols + col;
        localparam int node_b = ((bat + 1) * pe_rows + row) * pe_cols + col;
        localparam int node_u = (bat * (pe_rows + 1) + row) * pe_cols + col;
        localparam int node_d = (bat * (pe_rows + 1) + row + 1) * pe_cols + col;

        mac_pe #(
          .pe_row           (row)
        ) mac_pe_i (
          .clk              (clk),
          .INTERNAL_RESET   (core_rst),
          .data_in          (lr_beat[node_l]),
          .data_in_valid    (lr_valid[node_l]),
          .data_in_ready    (lr_ready[node_l]),
          .weight_in        (tb_beat[node_t]),
          .weight_in_valid  (tb_valid[node_t]),
          .weight_in_ready  (tb_ready[node_t]),
          .psum_in          (ud_beat[node_u]),
          .psum_in_valid    (ud_valid[node_u]),
          .psum_in_ready    (ud_ready[node_u]),
          .data_out         (lr_beat[node_r]),
          .data_out_valid   (lr_valid[node_r]),
          .data_out_ready   (lr_ready[node_r]),
          .weight_out       (tb_beat[node_b]),
          .weight_out_valid (tb_valid[node_b]),
          .weight_out_ready (tb_ready[node_b]),
          .psum_out         (ud_beat[node_d]),
          .psum_out_valid   (ud_valid[node_d]),
          .psum_out_ready   (ud_ready[node_d]),
          .err              (pe_err[uid])
        );

        // Left edge takes the data inputs
        if (col == 0) begin : g_left
          localparam int lft_pos = bat * pe_rows + row;

          assign lr_beat[node_l]        = data_in[lft_pos];
          assign lr_valid[node_l]       = data_in_valid[lft_pos];
          assign data_in_ready[lft_pos] = lr_ready[node_l];
        end

        // Right edge data is dropped
        if (col == pe_cols - 1) begin : g_right
          assign lr_ready[node_r] = 1'b1;
        end

        // Plane 0 takes the weight inputs
        if (bat == 0) begin : g_top
          localparam int top_pos = row * pe_cols + col;

          assign tb_beat[node_t]          = weight_in[top_pos];
          assign tb_valid[node_t]         = weight_in_valid[top_pos];
          assign weight_in_ready[top_pos] = tb_ready[node_t];
        end

        // Weights leaving the last plane are dropped
        if (bat == batches - 1) begin : g_bottom
          assign tb_ready[node_b] = 1'b1;
        end

        // Column sums start from zero
        if (row == 0) begin : g_up
          assign ud_beat[node_u]  = '0;
          assign ud_valid[node_u] = 1'b0;
        end

        // Bottom row sum, rescaled to Q4.12 with wraparound
        if (row == pe_rows - 1) begin : g_down
          localparam int dwn_pos = bat * pe_cols + col;

          assign rslt_out[dwn_pos].rslt  = ud_beat[node_d].psum[rslt_lsb +: rslt_width];
          assign rslt_out[dwn_pos].last  = ud_beat[node_d].last;
          assign rslt_out_valid[dwn_pos] = ud_valid[node_d];
          assign ud_ready[node_d]        = rslt_out_ready[dwn_pos];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/mac_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_pe #(
  // Row index within the column
  parameter int pe_row = 0
) (
  input  logic                      clk,
  input  logic                      INTERNAL_RESET,

  // Data from the left
  input  sysarr_pkg::data_beat_t    data_in,
  input  logic                      data_in_valid,
  output logic                      data_in_ready,

  // Weight from the previous batch plane
  input  sysarr_pkg::weight_beat_t  weight_in,
  input  logic                      weight_in_valid,
  output logic                      weight_in_ready,

  // Partial sum from the row above
  input  sysarr_pkg::psum_beat_t    psum_in,
  input  logic                      psum_in_valid,
  output logic                      psum_in_ready,

  // Data to the right
  output sysarr_pkg::data_beat_t    data_out,
  output logic                      data_out_valid,
  input  logic                      data_out_ready,

  // Weight to the next batch plane
  output sysarr_pkg::weight_beat_t  weight_out,
  output logic                      weight_out_valid,
  input  logic                      weight_out_ready,

  // Partial sum to the row below
  output sysarr_pkg::psum_beat_t    psum_out,
  output logic                      psum_out_valid,
  input  logic                      psum_out_ready,

  output logic                      err
);

  import sysarr_pkg::*;

  logic                         data_free;
  logic                         weight_free;
  logic                         psum_free;
  logic                         psum_in_ok;
  logic                         fire;
  logic signed [psum_width-1:0] product;
  logic signed [psum_width-1:0] psum_base;
  logic signed [psum_width-1:0] psum_sum;

  // An output register can take a new beat when empty or drained this cycle
  assign data_free   = !data_out_valid   || data_out_ready;
  assign weight_free = !weight_out_valid || weight_out_ready;
  assign psum_free   = !psum_out_valid   || psum_out_ready;

  // Row 0 has nothing above it to wait for
  assign psum_in_ok = (pe_row == 0) ? 1'b1 : psum_in_valid;
  assign psum_base  = (pe_row == 0) ? '0 : psum_in.psum;

  // Fire only with all inputs present and all three outputs free
  assign fire = data_in_valid && weight_in_valid && psum_in_ok &&
                data_free && weight_free && psum_free;

  assign data_in_ready   = fire;
  assign weight_in_ready = fire;
  assign psum_in_ready   = fire && (pe_row != 0);

  // Signed Q4.12 x Q4.12 product at full width without rounding
  assign product  = psum_width'($signed(data_in.data)) *
                    psum_width'($signed(weight_in.weight));
  assign psum_sum = psum_base + product;

  // Output valids and sticky error flag
  always_ff @(posedge clk) begin
    if (INTERNAL_RESET) begin
      data_out_valid   <= 1'b0;
      weight_out_valid <= 1'b0;
      psum_out_valid   <= 1'b0;
      err              <= 1'b0;
    end else begin
      if (fire) begin
        data_out_valid <= 1'b1;
      end else if (data_out_ready) begin
        data_out_valid <= 1'b0;
      end

      if (fire) begin
        weight_out_valid <= 1'b1;
      end else if (weight_out_ready) begin
        weight_out_valid <= 1'b0;
      end

      if (fire) begin
        psum_out_valid <= 1'b1;
      end else if (psum_out_ready) begin
        psum_out_valid <= 1'b0;
      end

      // Data and weight sequences must end on the same beat
      if (fire && (data_in.last != weight_in.last)) begin
        err <= 1'b1;
      end
    end
  end

  // Payload registers load together on a firing
  always_ff @(posedge clk) begin
    if (fire) begin
      data_out      <= data_in;
      weight_out    <= weight_in;
      psum_out.psum <= psum_sum;
      psum_out.last <= data_in.last;
    end
  end

endmodule

`default_nettype wire

/* hdl/sysarr_pkg.sv */
`default_nettype none

package sysarr_pkg;

  // Operand and result formats, all Q4.12
  localparam int op0_width  = 16;
  localparam int op1_width  = 16;
  localparam int rslt_width = 16;

  localparam int op0_frac  = 12;
  localparam int op1_frac  = 12;
  localparam int rslt_frac = 12;

  // Full product width, carried unchanged down each column
  localparam int psum_width = op0_width + op1_width;

  // First partial-sum bit of the rescaled result
  localparam int rslt_lsb = op0_frac + op1_frac - rslt_frac;

  // Data beat, moves left to right along a row
  typedef struct packed {
    logic signed [op0_width-1:0]  data;
    logic                         last;
  } data_beat_t;

  // Weight beat, moves from one batch plane to the next
  typedef struct packed {
    logic signed [op1_width-1:0]  weight;
    logic                         last;
  } weight_beat_t;

  // Partial sum, moves down a column
  typedef struct packed {
    logic signed [psum_width-1:0] psum;
    logic                         last;
  } psum_beat_t;

  // Rescaled column result
  typedef struct packed {
    logic signed [rslt_width-1:0] rslt;
    logic                         last;
  } rslt_beat_t;

endpackage

`default_nettype wire

/* hdl/sysarr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sysarr_top #(
  parameter int pe_cols        = 2,
  parameter int pe_rows        = 3,
  parameter int batches        = 2,
  parameter int err_self_reset = 1
) (
  input  logic                                              clk,
  input  logic                                              INTERNAL_RESET,

  input  sysarr_pkg::data_beat_t   [batches*pe_rows-1:0]    data_in,
  input  logic                     [batches*pe_rows-1:0]    data_in_valid,
  output logic                     [batches*pe_rows-1:0]    data_in_ready,

  input  sysarr_pkg::weight_beat_t [pe_rows*pe_cols-1:0]    weight_in,
  input  logic                     [pe_rows*pe_cols-1:0]    weight_in_valid,
  output logic                     [pe_rows*pe_cols-1:0]    weight_in_ready,

  output sysarr_pkg::rslt_beat_t   [batches*pe_cols-1:0]    rslt_out,
  output logic                     [batches*pe_cols-1:0]    rslt_out_valid,
  input  logic                     [batches*pe_cols-1:0]    rslt_out_ready,

  output logic                                              err_unaligned,
  output logic                                              core_rst
);

  // 2 x 3 grid, two batch planes, self-reset on error
  mac_array #(
    .pe_cols         (pe_cols),
    .pe_rows         (pe_rows),
    .batches         (batches),
    .err_self_reset  (err_self_reset)
  ) mac_array_i (
    .clk             (clk),
    .INTERNAL_RESET  (INTERNAL_RESET),
    .data_in         (data_in),
    .data_in_valid   (data_in_valid),
    .data_in_ready   (data_in_ready),
    .weight_in       (weight_in),
    .weight_in_valid (weight_in_valid),
    .weight_in_ready (weight_in_ready),
    .rslt_out        (rslt_out),
    .rslt_out_valid  (rslt_out_valid),
    .rslt_out_ready  (rslt_out_ready),
    .err_unaligned   (err_unaligned),
    .core_rst        (core_rst)
  );

endmodule

`default_nettype wire

/* testbench/sysarr_golden.txt */
# test <name> <beats> <expected err_unaligned>
# beat d0..d5 (batch*3+row) dlast w0..w5 (row*2+col) wlast r0..r3 (batch*2+col), hex Q4.12
test single_unit 1 0
beat 1000 1000 1000 1000 1000 1000 1 1000 2000 0800 f000 3000 0000 1 4800 1000 4800 1000

test single_neg 1 0
beat 2000 e000 0400 f800 1000 7000 1 1000 f000 3000 0800 4000 c000 1 d000 c000 e800 5000

test multi_beat 3 0
beat 0001 0001 0001 0001 0001 0001 0 0001 0001 0001 0001 0001 0001 0 0000 0000 0000 0000
beat ffff ffff ffff ffff ffff ffff 0 0001 0001 0001 0001 0001 0001 0 ffff ffff ffff ffff
beat 1000 1000 1000 0800 0800 0800 1 1000 1000 1000 1000 1000 1000 1 3000 3000 1800 1800

test gaps_backpressure 4 0
beat 0800 0800 0800 0800 0800 0800 0 1000 1000 1000 1000 1000 1000 0 1800 1800 1800 1800
beat 1000 1000 1000 1000 1000 1000 0 2000 2000 2000 2000 2000 2000 0 6000 6000 6000 6000
beat f000 f000 f000 f000 f000 f000 0 1000 1000 1000 1000 1000 1000 0 d000 d000 d000 d000
beat 0100 0100 0100 0100 0100 0100 1 1000 1000 1000 1000 1000 1000 1 0300 0300 0300 0300

test unaligned_err 1 1
beat 1000 1000 1000 1000 1000 1000 1 1000 1000 1000 1000 1000 1000 0 0000 0000 0000 0000

test after_err 1 0
beat 1000 1000 1000 1000 1000 1000 1 1000 1000 1000 1000 1000 1000 1 3000 3000 3000 3000

/* testbench/tb_sysarr_checks.svh */
`ifndef TB_SYSARR_CHECKS_SVH
`define TB_SYSARR_CHECKS_SVH

// Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1
function automatic logic next_rand_bit();
  logic lsb;
  lsb = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (lsb) begin
    lfsr_state = lfsr_state ^ 32'hA3000000;
  end
  return lsb;
endfunction

task automatic fail_run(input string why);
  $display("%s", why);
  $display("STATUS: FAIL");
  $fatal(1, "simulation stopped");
endtask

// One result beat against its expected value
task automatic check_rslt(
  input string                  name,
  input int                     idx,
  input sysarr_pkg::rslt_beat_t exp,
  input sysarr_pkg::rslt_beat_t act
);
  if (act !== exp) begin
    fail_run($sformatf(
      "Error: test %s rslt_out[%0d] expected rslt=%h last=%b, actual rslt=%h last=%b",
      name, idx, exp.rslt, exp.last, act.rslt, act.last));
  end
endtask

// Single status level
task automatic check_flag(
  input string name,
  input string what,
  input logic  exp,
  input logic  act
);
  if (act !== exp) begin
    fail_run($sformatf("Error: test %s %s expected %b, actual %b",
                       name, what, exp, act));
  end
endtask

`endif

/* testbench/tb_sysarr.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sysarr;

  import sysarr_pkg::*;

  // Golden file layout matches the DUT parameters
  localparam int n_cols = 2;
  localparam int n_rows = 3;
  localparam int n_bats = 2;
  localparam int n_dat  = n_bats * n_rows;
  localparam int n_wgt  = n_rows * n_cols;
  localparam int n_res  = n_bats * n_cols;
  localparam int max_tests = 16;
  localparam int max_beats = 64;

  logic                              clk;
  logic                              INTERNAL_RESET;
  data_beat_t   [n_dat-1:0]          data_in;
  logic         [n_dat-1:0]          data_in_valid;
  logic         [n_dat-1:0]          data_in_ready;
  weight_beat_t [n_wgt-1:0]          weight_in;
  logic         [n_wgt-1:0]          weight_in_valid;
  logic         [n_wgt-1:0]          weight_in_ready;
  rslt_beat_t   [n_res-1:0]          rslt_out;
  logic         [n_res-1:0]          rslt_out_valid;
  logic         [n_res-1:0]          rslt_out_ready;
  logic                              err_unaligned;
  logic                              core_rst;

  // Golden records
  string        t_name   [max_tests];
  int           t_first  [max_tests];
  int           t_count  [max_tests];
  logic         t_err    [max_tests];
  logic [15:0]  b_data   [max_beats][n_dat];
  logic [15:0]  b_weight [max_beats][n_wgt];
  logic [15:0]  b_rslt   [max_beats][n_res];
  logic         b_dlast  [max_beats];
  logic         b_wlast  [max_beats];
  int           n_tests;
  int           n_beats;

  // Stream driver and monitor state
  int           d_ptr [n_dat];
  int           w_ptr [n_wgt];
  logic [n_dat-1:0] d_taken;
  logic [n_wgt-1:0] w_taken;
  rslt_beat_t   exp_q [n_res][$];
  logic         checking;
  string        cur_name;
  logic [31:0]  lfsr_state;
  int           cycles;
  int           cycle_limit;
  int           rst_stretch;

  `include "tb_sysarr_checks.svh"

  sysarr_top sysarr_top_i (
    .clk             (clk),
    .INTERNAL_RESET  (INTERNAL_RESET),
    .data_in         (data_in),
    .data_in_valid   (data_in_valid),
    .data_in_ready   (data_in_ready),
    .weight_in       (weight_in),
    .weight_in_valid (weight_in_valid),
    .weight_in_ready (weight_in_ready),
    .rslt_out        (rslt_out),
    .rslt_out_valid  (rslt_out_valid),
    .rslt_out_ready  (rslt_out_ready),
    .err_unaligned   (err_unaligned),
    .core_rst        (core_rst)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit is set once the golden beats are counted
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles in test %s", cycles, cur_name));
    end
  end

  // Result monitor samples transfers at the falling edge
  always @(negedge clk) begin
    if (checking) begin
      for (int r = 0; r < n_res; r++) begin
        if (rslt_out_valid[r] && rslt_out_ready[r]) begin
          if (exp_q[r].size() == 0) begin
            fail_run($sformatf("Test %s produced an extra beat on rslt_out[%0d]",
                               cur_name, r));
          end else begin
            check_rslt(cur_name, r, exp_q[r].pop_front(), rslt_out[r]);
          end
        end
      end
    end
  end

  // Idle about one cycle in four
  function automatic logic gap_now();
    logic a;
    logic b;
    a = next_rand_bit();
    b = next_rand_bit();
    return a & b;
  endfunction

  task automatic load_golden();
    int    fd;
    int    cnt;
    int    ef;
    int    dl;
    int    wl;
    int    total;
    string line;
    string kw;
    string nm;
    logic [15:0] dv [n_dat];
    logic [15:0] wv [n_wgt];
    logic [15:0] rv [n_res];
    fd = $fopen("testbench/sysarr_golden.txt", "r");
    if (fd == 0) begin
      fail_run("Cannot open testbench/sysarr_golden.txt");
    end
    n_tests = 0;
    n_beats = 0;
    total   = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%s", kw) != 1) continue;
      if (kw == "test") begin
        if ($sscanf(line, "test %s %d %d", nm, cnt, ef) != 3) begin
          fail_run($sformatf("Bad test line in golden file: %s", line));
        end
        t_name[n_tests]  = nm;
        t_first[n_tests] = n_beats;
        t_count[n_tests] = cnt;
        t_err[n_tests]   = (ef != 0);
        total += cnt;
        n_tests++;
      end else begin
        if ($sscanf(line, "beat %h %h %h %h %h %h %d %h %h %h %h %h %h %d %h %h %h %h",
                    dv[0], dv[1], dv[2], dv[3], dv[4], dv[5], dl,
                    wv[0], wv[1], wv[2], wv[3], wv[4], wv[5], wl,
                    rv[0], rv[1], rv[2], rv[3]) != 18) begin
          fail_run($sformatf("Bad beat line in golden file: %s", line));
        end
        for (int s = 0; s < n_dat; s++) b_data[n_beats][s] = dv[s];
        for (int s = 0; s < n_wgt; s++) b_weight[n_beats][s] = wv[s];
        for (int r = 0; r < n_res; r++) b_rslt[n_beats][r] = rv[r];
        b_dlast[n_beats] = (dl != 0);
        b_wlast[n_beats] = (wl != 0);
        n_beats++;
      end
    end
    $fclose(fd);
    if (total != n_beats || n_tests == 0) begin
      fail_run("Golden file beat counts do not match its test records");
    end
  endtask

  // Retire taken beats, then offer the next ones after random gaps
  task automatic drive_streams(input int stop);
    for (int s = 0; s < n_dat; s++) begin
      if (d_taken[s]) begin
        data_in_valid[s] = 1'b0;
        d_ptr[s]++;
      end
      if (!data_in_valid[s] && d_ptr[s] < stop && !gap_now()) begin
        data_in[s].data  = b_data[d_ptr[s]][s];
        data_in[s].last  = b_dlast[d_ptr[s]];
        data_in_valid[s] = 1'b1;
      end
    end
    for (int s = 0; s < n_wgt; s++) begin
      if (w_taken[s]) begin
        weight_in_valid[s] = 1'b0;
        w_ptr[s]++;
      end
      if (!weight_in_valid[s] && w_ptr[s] < stop && !gap_now()) begin
        weight_in[s].weight = b_weight[w_ptr[s]][s];
        weight_in[s].last   = b_wlast[w_ptr[s]];
        weight_in_valid[s]  = 1'b1;
      end
    end
  endtask

  task automatic set_ready(input logic hold);
    for (int r = 0; r < n_res; r++) begin
      rslt_out_ready[r] = hold ? 1'b0 : !gap_now();
    end
  endtask

  function automatic logic work_left(input int stop);
    logic left;
    left = (|data_in_valid) || (|weight_in_valid);
    for (int s = 0; s < n_dat; s++) left = left || (d_ptr[s] < stop);
    for (int s = 0; s < n_wgt; s++) left = left || (w_ptr[s] < stop);
    for (int r = 0; r < n_res; r++) left = left || (exp_q[r].size() != 0);
    return left;
  endfunction

  task automatic run_test(input int t);
    int         stop;
    logic       seen_err;
    logic       seen_rst;
    logic       busy;
    rslt_beat_t exp_beat;
    cur_name = t_name[t];
    stop     = t_first[t] + t_count[t];
    seen_err = 1'b0;
    seen_rst = 1'b0;
    for (int s = 0; s < n_dat; s++) d_ptr[s] = t_first[t];
    for (int s = 0; s < n_wgt; s++) w_ptr[s] = t_first[t];
    // Results of an unaligned sequence are flushed by the core reset
    checking = !t_err[t];
    if (!t_err[t]) begin
      for (int b = t_first[t]; b < stop; b++) begin
        for (int r = 0; r < n_res; r++) begin
          exp_beat.rslt = b_rslt[b][r];
          exp_beat.last = b_dlast[b];
          exp_q[r].push_back(exp_beat);
        end
      end
    end
    d_taken = '0;
    w_taken = '0;
    drive_streams(stop);
    set_ready(t_err[t]);
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      d_taken = data_in_valid & data_in_ready;
      w_taken = weight_in_valid & weight_in_ready;
      if (err_unaligned) seen_err = 1'b1;
      if (core_rst) seen_rst = 1'b1;
      @(posedge clk);
      #2;
      drive_streams(stop);
      set_ready(t_err[t]);
      busy = t_err[t] ? !seen_rst : work_left(stop);
    end
    check_flag(cur_name, "err_unaligned", t_err[t], seen_err);
    if (t_err[t]) begin
      data_in_valid   = '0;
      weight_in_valid = '0;
      @(negedge clk);
      while (core_rst) @(negedge clk);
      check_flag(cur_name, "err_unaligned after core reset", 1'b0, err_unaligned);
      check_flag(cur_name, "rslt_out_valid after core reset", 1'b0, |rslt_out_valid);
      @(posedge clk);
      #2;
      rslt_out_ready = '1;
    end
  endtask

  initial begin
    INTERNAL_RESET  = 1'b1;
    data_in         = '0;
    data_in_valid   = '0;
    weight_in       = '0;
    weight_in_valid = '0;
    rslt_out_ready  = '1;
    checking        = 1'b0;
    cur_name        = "reset";
    lfsr_state      = 32'h16fe411f;
    cycles          = 0;
    cycle_limit     = 0;
    rst_stretch     = 0;
    if (sysarr_top_i.pe_cols != n_cols || sysarr_top_i.pe_rows != n_rows ||
        sysarr_top_i.batches != n_bats) begin
      fail_run("DUT array size does not match the golden file layout");
    end
    load_golden();
    cycle_limit = 64 * n_beats + 200;
    repeat (4) @(posedge clk);
    #2;
    INTERNAL_RESET = 1'b0;
    // Stretch counted from the first edge that sees the reset low
    @(negedge clk);
    @(negedge clk);
    while (core_rst) begin
      rst_stretch++;
      @(negedge clk);
    end
    check_flag("reset", "rslt_out_valid", 1'b0, |rslt_out_valid);
    check_flag("reset", "err_unaligned", 1'b0, err_unaligned);
    check_flag("reset", "core_rst held three cycles past reset", 1'b1, rst_stretch >= 3);
    @(posedge clk);
    #2;
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
